//--- all.f
design/mlu_pkg.sv
design/boot_counter.sv
design/boot_fsm.sv
design/slice_table_gen.sv
design/mlu_slice.sv
design/mlu_lookahead.sv
design/mlu.sv
design/mlu_unit.sv
test/tb_clock.sv
test/tb_mlu_checker.sv
test/mlu_unit_assert.sv
test/tb_mlu_unit.sv

//--- Bender.yml
package:
  name: mlu_unit

sources:
  - design/mlu_pkg.sv
  - design/boot_counter.sv
  - design/boot_fsm.sv
  - design/slice_table_gen.sv
  - design/mlu_slice.sv
  - design/mlu_lookahead.sv
  - design/mlu.sv
  - design/mlu_unit.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_mlu_checker.sv
      - test/mlu_unit_assert.sv
      - test/tb_mlu_unit.sv

//--- test/tb_mlu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mlu_unit;

  localparam int clk_period = 20;
  localparam int reset_cycles = 3;
  localparam int drive_delay = 2;
  localparam int result_latency = 2;
  localparam int data_w = mlu_pkg::data_width;

  localparam int pre_boot_reqs = 10;
  localparam int arith_reqs = 16 + 200;
  localparam int logic_reqs = 6 * 30;
  localparam int flag_reqs = 32;
  localparam int burst_reqs = 200;
  localparam int total_reqs = pre_boot_reqs + arith_reqs + logic_reqs + flag_reqs + burst_reqs;
  localparam int timeout_cycles = mlu_pkg::table_depth + 2 * total_reqs + 100;

  logic              clk;
  logic              rst;
  logic              req_valid;
  mlu_pkg::mlu_req_t req;
  logic              booted;
  logic              res_valid;
  mlu_pkg::mlu_res_t res;
  mlu_pkg::mlu_res_t exp_res;
  int                mismatch_count;
  int                protocol_errors;
  int                accepted_count;
  int                result_count;
  int                sequence_errors = 0;
  int                timeout_errors = 0;
  logic [15:0]       lfsr = 16'd48;

  tb_clock #(
    .period       (clk_period),
    .reset_cycles (reset_cycles),
    .drive_delay  (drive_delay)
  ) i_tb_clock (
    .clk (clk),
    .rst (rst)
  );

  mlu_unit #(
    .num_slices (8)
  ) i_mlu_unit (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .booted    (booted),
    .res_valid (res_valid),
    .res       (res)
  );

  bind mlu_unit mlu_unit_assert i_mlu_unit_assert (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .booted    (booted),
    .res_valid (res_valid)
  );

  tb_mlu_checker i_tb_mlu_checker (
    .clk             (clk),
    .rst             (rst),
    .booted          (booted),
    .req_valid       (req_valid),
    .exp_res         (exp_res),
    .res_valid       (res_valid),
    .res             (res),
    .mismatch_count  (mismatch_count),
    .protocol_errors (protocol_errors),
    .accepted_count  (accepted_count),
    .result_count    (result_count)
  );

  // ##############################
  // Reference model.
  // ##############################

  function automatic mlu_pkg::mlu_res_t mlu_model(input mlu_pkg::mlu_req_t r);
    mlu_pkg::mlu_res_t m;
    logic [data_w:0]   wide;
    case (r.op)
      mlu_pkg::mlu_add: wide = {1'b0, r.a} + {1'b0, r.b} + (data_w+1)'(r.c_in);
      mlu_pkg::mlu_sub: wide = {1'b0, r.a} + {1'b0, ~r.b} + (data_w+1)'(r.c_in);
      mlu_pkg::mlu_and: wide = {1'b0, r.a & r.b};
      mlu_pkg::mlu_or:  wide = {1'b0, r.a | r.b};
      mlu_pkg::mlu_xor: wide = {1'b0, r.a ^ r.b};
      mlu_pkg::mlu_not: wide = {1'b0, ~r.a};
      default:          wide = '0;
    endcase
    m.out = wide[data_w-1:0];
    m.c = wide[data_w];
    m.z = (m.out == '0);
    m.n = m.out[data_w-1];
    return m;
  endfunction

  assign exp_res = mlu_model(req);

  // ##############################
  // Stimulus helpers.
  // ##############################

  // 16-bit Galois LFSR with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic send_req(input mlu_pkg::mlu_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic c_in);
    req_valid = 1'b1;
    req.op = op;
    req.a = a;
    req.b = b;
    req.c_in = c_in;
    next_cycle();
  endtask

  task automatic send_random(input mlu_pkg::mlu_op_e op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    take_bits(32, a);
    take_bits(32, b);
    take_bits(1, c);
    // Subtract needs carry in set.
    if (op == mlu_pkg::mlu_sub) begin
      c = 32'd1;
    end
    send_req(op, a, b, c[0]);
  endtask

  task automatic drain();
    req_valid = 1'b0;
    repeat (result_latency + 1) next_cycle();
  endtask

  task automatic finish_run();
    int total;
    total = mismatch_count + protocol_errors + sequence_errors + timeout_errors
            + i_mlu_unit.i_mlu_unit_assert.fail_count;
    $display("Errors: %0d mismatch, %0d protocol, %0d sequence, %0d assertion, %0d timeout",
             mismatch_count, protocol_errors, sequence_errors,
             i_mlu_unit.i_mlu_unit_assert.fail_count, timeout_errors);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ##############################
  // Test sequence.
  // ##############################

  initial begin : stimulus
    logic [31:0]       pick;
    logic [31:0]       a;
    int                burst_start;
    mlu_pkg::mlu_op_e  logic_ops [6];
    logic_ops = '{mlu_pkg::mlu_and, mlu_pkg::mlu_or, mlu_pkg::mlu_xor,
                  mlu_pkg::mlu_not, mlu_pkg::mlu_nop0, mlu_pkg::mlu_nop1};
    req_valid = 1'b0;
    req = '0;
    wait (rst === 1'b0);
    next_cycle();

    // Dropped while the tables load.
    repeat (pre_boot_reqs) send_random(mlu_pkg::mlu_add);
    drain();
    while (booted !== 1'b1) next_cycle();

    // Carry enters each slice boundary in turn.
    for (int k = 0; k < 8; k++) begin
      send_req(mlu_pkg::mlu_add, 32'hFFFF_FFFF >> (4 * k), 32'd1, 1'b0);
      send_req(mlu_pkg::mlu_add, 32'hFFFF_FFFF >> (4 * k), 32'd0, 1'b1);
    end
    repeat (200) begin
      take_bits(1, pick);
      send_random(pick[0] ? mlu_pkg::mlu_sub : mlu_pkg::mlu_add);
    end
    drain();

    foreach (logic_ops[i]) begin
      repeat (30) send_random(logic_ops[i]);
    end
    drain();

    // Zero results.
    repeat (16) begin
      take_bits(32, a);
      take_bits(1, pick);
      send_req(mlu_pkg::mlu_sub, a, a, 1'b1);
      send_req(mlu_pkg::mlu_xor, a, a, pick[0]);
    end
    drain();

    burst_start = result_count;
    repeat (burst_reqs) begin
      take_bits(3, pick);
      send_random(mlu_pkg::mlu_op_e'(pick[2:0]));
    end
    drain();
    if (result_count - burst_start != burst_reqs) begin
      $display("Error: burst of %0d requests returned %0d results",
               burst_reqs, result_count - burst_start);
      sequence_errors++;
    end
    if (accepted_count != result_count) begin
      $display("Error: %0d accepted requests never returned a result",
               accepted_count - result_count);
      sequence_errors++;
    end
    finish_run();
  end

  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("Error: run timed out after %0d cycles", timeout_cycles);
    timeout_errors = 1;
    finish_run();
  end

endmodule : tb_mlu_unit

`default_nettype wire

//--- test/mlu_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mlu_unit_assert (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic booted,
  input logic res_valid
);

  int fail_count = 0;

  a_no_result_unbooted : assert property (
    @(posedge clk) disable iff (rst) !booted |-> !res_valid
  ) else begin
    fail_count++;
    $error("res_valid high while booted is low");
  end

  a_booted_holds : assert property (
    @(posedge clk) disable iff (rst) booted |=> booted
  ) else begin
    fail_count++;
    $error("booted fell without reset");
  end

  // Two register stages between request and result.
  a_result_follows : assert property (
    @(posedge clk) disable iff (rst) (req_valid && booted) |-> ##2 res_valid
  ) else begin
    fail_count++;
    $error("accepted request not followed by res_valid two cycles later");
  end

  a_no_spurious_result : assert property (
    @(posedge clk) disable iff (rst) res_valid |-> $past(req_valid && booted, 2)
  ) else begin
    fail_count++;
    $error("res_valid without a request accepted two cycles earlier");
  end

endmodule : mlu_unit_assert

`default_nettype wire

//--- test/tb_mlu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mlu_checker (
  input  logic              clk,
  input  logic              rst,
  input  logic              booted,
  input  logic              req_valid,
  input  mlu_pkg::mlu_res_t exp_res,
  input  logic              res_valid,
  input  mlu_pkg::mlu_res_t res,
  output int                mismatch_count,
  output int                protocol_errors,
  output int                accepted_count,
  output int                result_count
);

  // One clear cycle and then one write per table entry.
  localparam int boot_cycles_expected = mlu_pkg::table_depth + 1;

  mlu_pkg::mlu_res_t exp_q [$];
  int                boot_cycles;
  logic              booted_seen;

  initial begin
    mismatch_count = 0;
    protocol_errors = 0;
    accepted_count = 0;
    result_count = 0;
    boot_cycles = 0;
    booted_seen = 1'b0;
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
      mismatch_count++;
    end
  endtask

  // Sampled mid-cycle where inputs and outputs are stable.
  always @(negedge clk) begin : monitor
    mlu_pkg::mlu_res_t expected;
    if (rst) begin
      boot_cycles = 0;
      booted_seen = 1'b0;
      exp_q.delete();
    end else begin
      if (!booted) begin
        if (booted_seen) begin
          $display("Error: booted fell while reset was low");
          protocol_errors++;
          booted_seen = 1'b0;
        end
        boot_cycles++;
      end else if (!booted_seen) begin
        booted_seen = 1'b1;
        check_field("boot_cycles", boot_cycles, boot_cycles_expected);
      end
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          $display("Error: res_valid pulsed with no accepted request outstanding");
          protocol_errors++;
        end else begin
          expected = exp_q.pop_front();
          result_count++;
          check_field("res.out", res.out, expected.out);
          check_field("res.z", res.z, expected.z);
          check_field("res.c", res.c, expected.c);
          check_field("res.n", res.n, expected.n);
        end
      end
      if (req_valid && booted) begin
        exp_q.push_back(exp_res);
        accepted_count++;
      end
    end
  end

endmodule : tb_mlu_checker

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period = 20,
  parameter int reset_cycles = 3,
  parameter int drive_delay = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2);
      clk = ~clk;
    end
  end

  // Reset falls a short delay after an edge.
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
  end

endmodule : tb_clock

`default_nettype wire

//--- design/mlu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mlu_unit #(
  parameter int num_slices = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  mlu_pkg::mlu_req_t req,
  output logic              booted,
  output logic              res_valid,
  output mlu_pkg::mlu_res_t res
);

  logic                  boot_clear;
  logic                  boot_step;
  logic                  boot_we;
  logic                  boot_last;
  mlu_pkg::slice_addr_u  boot_addr;
  mlu_pkg::slice_entry_t boot_data;
  mlu_pkg::boot_write_t  boot_wr;

  mlu_pkg::mlu_req_t     req_q;
  logic                  req_q_valid;
  mlu_pkg::mlu_res_t     mlu_res;

  // ##############################
  // Bootstrap loader.
  // ##############################

  boot_fsm i_boot_fsm (
    .clk    (clk),
    .rst    (rst),
    .last   (boot_last),
    .clear  (boot_clear),
    .step   (boot_step),
    .we     (boot_we),
    .booted (booted)
  );

  boot_counter i_boot_counter (
    .clk   (clk),
    .rst   (rst),
    .clear (boot_clear),
    .step  (boot_step),
    .addr  (boot_addr),
    .last  (boot_last)
  );

  slice_table_gen i_table_gen (
    .addr (boot_addr),
    .data (boot_data)
  );

  // Same write goes to every slice.
  assign boot_wr = '{we: boot_we, addr: boot_addr, data: boot_data};

  // ##############################
  // Request and result stages.
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      req_q_valid <= req_valid & booted;
      res_valid <= req_q_valid;
    end
  end

  // Requests before booted are dropped.
  always_ff @(posedge clk) begin
    if (req_valid && booted) begin
      req_q <= req;
    end
    if (req_q_valid) begin
      res <= mlu_res;
    end
  end

  mlu #(
    .num_slices (num_slices)
  ) i_mlu (
    .clk  (clk),
    .req  (req_q),
    .boot (boot_wr),
    .res  (mlu_res)
  );

endmodule : mlu_unit

`default_nettype wire

//--- design/mlu.sv
`timescale 1ns/1ps
`default_nettype none

module mlu #(
  parameter int num_slices = 8
) (
  input  logic                 clk,
  input  mlu_pkg::mlu_req_t    req,
  input  mlu_pkg::boot_write_t boot,
  output mlu_pkg::mlu_res_t    res
);

  localparam int sw = mlu_pkg::slice_width;
  localparam int width = num_slices * sw;
  localparam int data_w = mlu_pkg::data_width;
  localparam int z_pairs = (num_slices + 1) / 2;

  mlu_pkg::slice_entry_t entry [num_slices];
  logic [num_slices-1:0] slice_p;
  logic [num_slices-1:0] slice_g;
  logic [num_slices-1:0] slice_z;
  logic [num_slices:0]   carry;
  logic [width-1:0]      sum;
  logic [z_pairs-1:0]    z_level0;

  // ##############################
  // Slices and carries.
  // ##############################

  assign carry[0] = req.c_in;

  for (genvar i = 0; i < num_slices; i++) begin : g_slice
    mlu_slice i_slice (
      .clk   (clk),
      .a     (req.a[i*sw +: sw]),
      .b     (req.b[i*sw +: sw]),
      .op    (req.op),
      .c_in  (carry[i]),
      .boot  (boot),
      .entry (entry[i])
    );
    assign sum[i*sw +: sw] = entry[i].out;
    assign slice_p[i] = entry[i].p;
    assign slice_g[i] = entry[i].g;
    assign slice_z[i] = entry[i].z;
  end

  mlu_lookahead #(
    .num_slices (num_slices)
  ) i_lookahead (
    .c_in  (req.c_in),
    .p     (slice_p),
    .g     (slice_g),
    .carry (carry[num_slices:1])
  );

  // ##############################
  // Zero tree and flags.
  // ##############################

  for (genvar k = 0; k < z_pairs; k++) begin : g_z_level0
    if (2 * k + 1 < num_slices) begin : g_pair
      assign z_level0[k] = slice_z[2*k] & slice_z[2*k+1];
    end else begin : g_single
      assign z_level0[k] = slice_z[2*k];
    end
  end

  always_comb begin
    res.out = data_w'(sum);
    res.z = &z_level0;
    res.c = carry[num_slices];
    res.n = sum[width-1];
  end

endmodule : mlu

`default_nettype wire

//--- design/mlu_lookahead.sv
`timescale 1ns/1ps
`default_nettype none

module mlu_lookahead #(
  parameter int num_slices = 8
) (
  input  logic                  c_in,
  input  logic [num_slices-1:0] p,
  input  logic [num_slices-1:0] g,
  output logic [num_slices-1:0] carry
);

  // Sum of products per carry with no ripple between slices.
  always_comb begin
    logic term;
    for (int i = 0; i < num_slices; i++) begin
      term = c_in;
      for (int k = 0; k <= i; k++) begin
        term = term & p[k];
      end
      carry[i] = term;
      for (int j = 0; j <= i; j++) begin
        term = g[j];
        for (int k = j + 1; k <= i; k++) begin
          term = term & p[k];
        end
        carry[i] = carry[i] | term;
      end
    end
  end

endmodule : mlu_lookahead

`default_nettype wire

//--- design/mlu_slice.sv
`timescale 1ns/1ps
`default_nettype none

module mlu_slice (
  input  logic                              clk,
  input  logic [mlu_pkg::slice_width-1:0]   a,
  input  logic [mlu_pkg::slice_width-1:0]   b,
  input  mlu_pkg::mlu_op_e                  op,
  input  logic                              c_in,
  input  mlu_pkg::boot_write_t              boot,
  output mlu_pkg::slice_entry_t             entry
);

  mlu_pkg::slice_entry_t table_mem [mlu_pkg::table_depth];
  mlu_pkg::slice_addr_u  rd_addr;

  // Loaded once by the bootstrap.
  always_ff @(posedge clk) begin
    if (boot.we) begin
      table_mem[boot.addr.raw] <= boot.data;
    end
  end

  always_comb begin
    rd_addr.fields.op = op;
    rd_addr.fields.c_in = c_in;
    rd_addr.fields.b = b;
    rd_addr.fields.a = a;
  end

  assign entry = table_mem[rd_addr.raw];

endmodule : mlu_slice

`default_nettype wire

//--- design/slice_table_gen.sv
`timescale 1ns/1ps
`default_nettype none

module slice_table_gen (
  input  mlu_pkg::slice_addr_u  addr,
  output mlu_pkg::slice_entry_t data
);

  localparam int w = mlu_pkg::slice_width;

  logic [w-1:0] b_in;
  logic [w:0]   sum0;
  logic [w-1:0] sum;

  always_comb begin
    // Subtract is add with b inverted and carry in set.
    if (addr.fields.op == mlu_pkg::mlu_sub) begin
      b_in = ~addr.fields.b;
    end else begin
      b_in = addr.fields.b;
    end
    sum0 = {1'b0, addr.fields.a} + {1'b0, b_in};
    sum = sum0[w-1:0] + {{(w-1){1'b0}}, addr.fields.c_in};

    data = '0;
    case (addr.fields.op)
      mlu_pkg::mlu_add,
      mlu_pkg::mlu_sub: begin
        data.out = sum;
        data.g = sum0[w];
        data.p = (sum0 == (w+1)'((1 << w) - 1));
      end
      mlu_pkg::mlu_and: data.out = addr.fields.a & addr.fields.b;
      mlu_pkg::mlu_or:  data.out = addr.fields.a | addr.fields.b;
      mlu_pkg::mlu_xor: data.out = addr.fields.a ^ addr.fields.b;
      mlu_pkg::mlu_not: data.out = ~addr.fields.a;
      default: begin
        data.out = '0;
      end
    endcase
    data.z = (data.out == '0);
  end

endmodule : slice_table_gen

`default_nettype wire

//--- design/boot_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module boot_fsm (
  input  logic clk,
  input  logic rst,
  input  logic last,
  output logic clear,
  output logic step,
  output logic we,
  output logic booted
);

  typedef enum logic [1:0] {
    st_reset,
    st_loading,
    st_booted
  } state_e;

  state_e state;
  state_e state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_reset;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    clear = 1'b0;
    step = 1'b0;
    we = 1'b0;
    booted = 1'b0;
    case (state)
      st_reset: begin
        clear = 1'b1;
        state_next = st_loading;
      end
      st_loading: begin
        // One table address per cycle.
        we = 1'b1;
        step = 1'b1;
        if (last) begin
          state_next = st_booted;
        end
      end
      st_booted: begin
        booted = 1'b1;
      end
      default: begin
        state_next = st_reset;
      end
    endcase
  end

endmodule : boot_fsm

`default_nettype wire

//--- design/boot_counter.sv
`timescale 1ns/1ps
`default_nettype none

module boot_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear,
  input  logic                 step,
  output mlu_pkg::slice_addr_u addr,
  output logic                 last
);

  localparam int addr_width = $bits(mlu_pkg::slice_addr_u);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      addr.raw <= '0;
    end else if (step) begin
      addr.raw <= addr.raw + addr_width'(1);
    end
  end

  // Final table index.
  assign last = (addr.raw == addr_width'(mlu_pkg::table_depth - 1));

endmodule : boot_counter

`default_nettype wire

//--- design/mlu_pkg.sv
`default_nettype none

package mlu_pkg;

  // ##############################
  // Widths.
  // ##############################

  localparam int slice_width = 4;
  localparam int table_depth = 4096;
  localparam int data_width = 32;

  typedef enum logic [2:0] {
    mlu_add  = 3'd0,
    mlu_sub  = 3'd1,
    mlu_and  = 3'd2,
    mlu_or   = 3'd3,
    mlu_xor  = 3'd4,
    mlu_not  = 3'd5,
    mlu_nop0 = 3'd6,
    mlu_nop1 = 3'd7
  } mlu_op_e;

  // ##############################
  // Slice table.
  // ##############################

  typedef struct packed {
    mlu_op_e                op;
    logic                   c_in;
    logic [slice_width-1:0] b;
    logic [slice_width-1:0] a;
  } slice_fields_t;

  // Counter value and operand fields are the same 12 bits.
  typedef union packed {
    logic [$bits(slice_fields_t)-1:0] raw;
    slice_fields_t                    fields;
  } slice_addr_u;

  typedef struct packed {
    logic                   unused;
    logic                   z;
    logic                   g;
    logic                   p;
    logic [slice_width-1:0] out;
  } slice_entry_t;

  typedef struct packed {
    logic         we;
    slice_addr_u  addr;
    slice_entry_t data;
  } boot_write_t;

  // ##############################
  // Requests and results.
  // ##############################

  typedef struct packed {
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    mlu_op_e               op;
    logic                  c_in;
  } mlu_req_t;

  typedef struct packed {
    logic [data_width-1:0] out;
    logic                  z;
    logic                  c;
    logic                  n;
  } mlu_res_t;

endpackage : mlu_pkg

`default_nettype wire
